//--- logic/mvm_consts.svh
////////////////////////////////////////////////////////////////////////////
// Matrix-vector multiplier constants
// Dimension, data widths and pipeline lengths
////////////////////////////////////////////////////////////////////////////

`ifndef MVM_CONSTS_SVH
`define MVM_CONSTS_SVH

// Matrix is MVM_DIM by MVM_DIM, vector has MVM_DIM elements
`define MVM_DIM 8

`define MVM_ELEM_W 12          // Input element width
`define MVM_ACC_W 24           // Result width, sums wrap here

`define MVM_MATRIX_ELEMS 64    // Elements per matrix load

// Last column read to settled lane sum
`define MVM_DRAIN_CYCLES 3

`endif

//--- logic/mvm_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Matrix-vector multiplier types
// Data vectors, index types and the job FSM state
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mvm_consts.svh"

package mvm_pkg;

    typedef logic signed [`MVM_ELEM_W-1:0] elem_t;   // Matrix or vector element
    typedef logic signed [`MVM_ACC_W-1:0] acc_t;     // Dot product, wraps

    typedef logic [$clog2(`MVM_DIM)-1:0] index_t;    // Column address or result row
    typedef logic [$clog2(`MVM_MATRIX_ELEMS)-1:0] count_t;

    typedef logic [`MVM_DIM-1:0] row_mask_t;         // One write enable per row

    // All lane sums side by side, entry i is row i
    typedef logic [`MVM_DIM-1:0][`MVM_ACC_W-1:0] sum_vec_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_MATRIX,
        LOAD_VECTOR,
        COMPUTE,
        DRAIN,
        OUTPUT
    } mvm_state_t;

endpackage

`default_nettype wire

//--- logic/mvm_control.sv
////////////////////////////////////////////////////////////////////////////
// Job controller
// Sequences matrix and vector loads, the MAC pass and the result stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mvm_consts.svh"

module mvm_control (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      input_valid,
    input  wire                      new_matrix,
    input  wire                      output_ready,
    input  wire mvm_pkg::count_t     count,
    input  wire                      at_last,
    output logic                     input_ready,
    output logic                     output_valid,
    output mvm_pkg::row_mask_t       row_write,
    output logic                     vector_write,
    output logic                     lane_clear,
    output logic                     lane_enable,
    output logic                     capture,
    output logic                     counter_clear,
    output logic                     counter_advance,
    output mvm_pkg::count_t          span_last
);

    mvm_pkg::mvm_state_t state;
    mvm_pkg::mvm_state_t next_state;
    logic                input_transfer;
    logic                output_transfer;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mvm_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            mvm_pkg::IDLE: begin
                // Only the job type is picked here and data follows from the next cycle
                if (input_valid) begin
                    next_state = new_matrix ? mvm_pkg::LOAD_MATRIX : mvm_pkg::LOAD_VECTOR;
                end
            end
            mvm_pkg::LOAD_MATRIX: if (input_transfer && at_last) next_state = mvm_pkg::LOAD_VECTOR;
            mvm_pkg::LOAD_VECTOR: if (input_transfer && at_last) next_state = mvm_pkg::COMPUTE;
            mvm_pkg::COMPUTE:     if (at_last) next_state = mvm_pkg::DRAIN;
            mvm_pkg::DRAIN:       if (at_last) next_state = mvm_pkg::OUTPUT;
            mvm_pkg::OUTPUT:      if (output_transfer && at_last) next_state = mvm_pkg::IDLE;
            default:              next_state = mvm_pkg::IDLE;
        endcase
    end

    assign input_ready = (state == mvm_pkg::LOAD_MATRIX) || (state == mvm_pkg::LOAD_VECTOR);
    assign output_valid = state == mvm_pkg::OUTPUT;
    assign input_transfer = input_valid && input_ready;
    assign output_transfer = output_valid && output_ready;

    // Counter starts from zero in every state
    assign counter_clear = (next_state != state) || (state == mvm_pkg::IDLE);
    assign counter_advance = input_transfer || output_transfer ||
                             (state == mvm_pkg::COMPUTE) || (state == mvm_pkg::DRAIN);

    always_comb begin
        case (state)
            mvm_pkg::LOAD_MATRIX: span_last = mvm_pkg::count_t'(`MVM_MATRIX_ELEMS - 1);
            mvm_pkg::DRAIN:       span_last = mvm_pkg::count_t'(`MVM_DRAIN_CYCLES - 1);
            default:              span_last = mvm_pkg::count_t'(`MVM_DIM - 1);
        endcase
    end

    // Upper count bits name the row being loaded
    always_comb begin
        row_write = '0;
        if (state == mvm_pkg::LOAD_MATRIX && input_transfer) begin
            row_write = mvm_pkg::row_mask_t'(1) << count[5:3];
        end
    end

    assign vector_write = (state == mvm_pkg::LOAD_VECTOR) && input_transfer;
    assign lane_clear = state == mvm_pkg::LOAD_VECTOR;   // Lanes idle while vector loads
    assign capture = (state == mvm_pkg::DRAIN) && at_last;

    // Memory read data lands one cycle after the column address
    always_ff @(posedge clk) begin
        if (reset) begin
            lane_enable <= 1'b0;
        end else begin
            lane_enable <= state == mvm_pkg::COMPUTE;
        end
    end

    // A stalled result keeps its row select until it is taken
    a_hold_output: assert property (
        @(posedge clk) disable iff (reset)
        (output_valid && !output_ready) |=> (output_valid && $stable(count))
    );

endmodule

`default_nettype wire

//--- logic/element_counter.sv
////////////////////////////////////////////////////////////////////////////
// Shared element counter
// Counts transfers or cycles from zero up to a programmable last value
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module element_counter (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  clear,
    input  wire                  advance,
    input  wire mvm_pkg::count_t span_last,
    output mvm_pkg::count_t      count,
    output logic                 at_last
);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;                    // Clear wins over advance
        end else if (advance) begin
            count <= count + 1'b1;
        end
    end

    assign at_last = count == span_last;

    // The owner must clear the count when it steps off the last value
    a_no_overrun: assert property (
        @(posedge clk) disable iff (reset) (advance && at_last) |-> clear
    );

endmodule

`default_nettype wire

//--- logic/operand_memory.sv
////////////////////////////////////////////////////////////////////////////
// Operand memory
// Eight element register file, synchronous write and registered read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mvm_consts.svh"

module operand_memory (
    input  wire                  clk,
    input  wire                  write,
    input  wire mvm_pkg::index_t address,
    input  wire mvm_pkg::elem_t  write_data,
    output mvm_pkg::elem_t       read_data
);

    mvm_pkg::elem_t storage [0:`MVM_DIM-1];

    always_ff @(posedge clk) begin
        if (write) begin
            storage[address] <= write_data;
        end
        read_data <= storage[address];      // One cycle read latency
    end

endmodule

`default_nettype wire

//--- logic/mac_lane.sv
////////////////////////////////////////////////////////////////////////////
// Pipelined MAC lane
// Registers a signed product, then adds it into a wrapping accumulator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mac_lane (
    input  wire                 clk,
    input  wire                 clear,
    input  wire                 enable,
    input  wire mvm_pkg::elem_t weight,
    input  wire mvm_pkg::elem_t operand,
    output mvm_pkg::acc_t       sum
);

    mvm_pkg::acc_t product;
    logic          product_valid;

    // Stage 1, full precision product fits the accumulator width
    always_ff @(posedge clk) begin
        if (clear) begin
            product       <= '0;
            product_valid <= 1'b0;
        end else begin
            product       <= weight * operand;
            product_valid <= enable;
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        if (clear) begin
            sum <= '0;
        end else if (product_valid) begin
            sum <= sum + product;          // Wraps modulo 2^24
        end
    end

    // Clear only comes between jobs
    a_clear_idle: assert property (@(posedge clk) clear |-> !enable);

endmodule

`default_nettype wire

//--- logic/result_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Result buffer
// Holds all lane sums of a job and drives the selected one out
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module result_buffer (
    input  wire                    clk,
    input  wire                    capture,
    input  wire mvm_pkg::sum_vec_t sums,
    input  wire mvm_pkg::index_t   select,
    output mvm_pkg::acc_t          data
);

    mvm_pkg::sum_vec_t stored;

    // Lanes may be cleared for the next job while results still drain out
    always_ff @(posedge clk) begin
        if (capture) begin
            stored <= sums;
        end
    end

    assign data = mvm_pkg::acc_t'(stored[select]);

endmodule

`default_nettype wire

//--- logic/mvm8.sv
////////////////////////////////////////////////////////////////////////////
// 8x8 signed matrix-vector multiplier
// Streams in a matrix and a vector, streams out eight dot products
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mvm_consts.svh"

module mvm8 (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 input_valid,
    output logic                input_ready,
    input  wire mvm_pkg::elem_t input_data,
    input  wire                 new_matrix,
    output logic                output_valid,
    input  wire                 output_ready,
    output mvm_pkg::acc_t       output_data
);

    mvm_pkg::count_t    count;
    mvm_pkg::count_t    span_last;
    mvm_pkg::index_t    column;             // Column address and result select
    mvm_pkg::row_mask_t row_write;
    mvm_pkg::elem_t     row_data [0:`MVM_DIM-1];
    mvm_pkg::elem_t     vector_data;
    mvm_pkg::sum_vec_t  lane_sums;
    logic               at_last;
    logic               counter_clear;
    logic               counter_advance;
    logic               vector_write;
    logic               lane_clear;
    logic               lane_enable;
    logic               capture;

    assign column = count[2:0];

    mvm_control control_i (
        .clk,
        .reset,
        .input_valid,
        .new_matrix,
        .output_ready,
        .count,
        .at_last,
        .input_ready,
        .output_valid,
        .row_write,
        .vector_write,
        .lane_clear,
        .lane_enable,
        .capture,
        .counter_clear,
        .counter_advance,
        .span_last
    );

    element_counter counter_i (
        .clk,
        .reset,
        .clear     (counter_clear),
        .advance   (counter_advance),
        .span_last,
        .count,
        .at_last
    );

    operand_memory vector_memory_i (
        .clk,
        .write      (vector_write),
        .address    (column),
        .write_data (input_data),
        .read_data  (vector_data)
    );

    // One row memory and one MAC lane per matrix row
    for (genvar r = 0; r < `MVM_DIM; r++) begin : g_row
        operand_memory row_memory_i (
            .clk,
            .write      (row_write[r]),
            .address    (column),
            .write_data (input_data),
            .read_data  (row_data[r])
        );

        mac_lane lane_i (
            .clk,
            .clear   (lane_clear),
            .enable  (lane_enable),
            .weight  (row_data[r]),
            .operand (vector_data),
            .sum     (lane_sums[r])
        );
    end

    result_buffer buffer_i (
        .clk,
        .capture,
        .sums   (lane_sums),
        .select (column),
        .data   (output_data)
    );

endmodule

`default_nettype wire

//--- testbench/mvm8_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the 8x8 matrix-vector multiplier
// Random and extreme jobs checked against a dot product reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mvm_consts.svh"

module mvm8_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_JOBS = 6;
    // Load with gaps, compute, drain and stalled output of one job
    localparam int JOB_CYCLES = 2 * (`MVM_MATRIX_ELEMS + `MVM_DIM) + 3 * `MVM_DIM + 20;
    localparam int WATCHDOG_CYCLES = 3 * (RESET_CYCLES + 10 + NUM_JOBS * JOB_CYCLES);

    localparam mvm_pkg::elem_t ELEM_MIN = mvm_pkg::elem_t'(-2048);
    localparam mvm_pkg::elem_t ELEM_MAX = mvm_pkg::elem_t'(2047);

    logic           clk;
    logic           reset;
    logic           input_valid;
    logic           input_ready;
    mvm_pkg::elem_t input_data;
    logic           new_matrix;
    logic           output_valid;
    logic           output_ready;
    mvm_pkg::acc_t  output_data;

    integer seed = 17421;
    int     results_seen;
    int     results_target;
    bit     stall_output;          // Random back-pressure in the current job
    string  current_test;

    mvm_pkg::elem_t matrix [0:`MVM_DIM-1][0:`MVM_DIM-1];
    mvm_pkg::elem_t operand_vector [0:`MVM_DIM-1];
    mvm_pkg::acc_t  expected_q [$];   // Results still owed in row order

    mvm8 mvm8_i (
        .clk,
        .reset,
        .input_valid,
        .input_ready,
        .input_data,
        .new_matrix,
        .output_valid,
        .output_ready,
        .output_data
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Row times vector kept to the low 24 bits
    function automatic mvm_pkg::acc_t dot_product(input int row);
        int sum;
        sum = 0;
        for (int j = 0; j < `MVM_DIM; j++) begin
            sum += int'(matrix[row][j]) * int'(operand_vector[j]);
        end
        return mvm_pkg::acc_t'(sum);
    endfunction

    task automatic check_result(input string name, input mvm_pkg::acc_t expected,
                                input mvm_pkg::acc_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Control level mismatch");
        end
    endtask

    task automatic random_matrix();
        for (int r = 0; r < `MVM_DIM; r++) begin
            for (int c = 0; c < `MVM_DIM; c++) begin
                matrix[r][c] = mvm_pkg::elem_t'($random(seed));
            end
        end
    endtask

    task automatic random_vector();
        for (int c = 0; c < `MVM_DIM; c++) begin
            operand_vector[c] = mvm_pkg::elem_t'($random(seed));
        end
    endtask

    // All minimum values or rows with a growing run of maximum values
    task automatic extreme_operands(input bit mixed);
        for (int r = 0; r < `MVM_DIM; r++) begin
            for (int c = 0; c < `MVM_DIM; c++) begin
                if (mixed && (c < r)) matrix[r][c] = ELEM_MAX;
                else matrix[r][c] = ELEM_MIN;
            end
        end
        for (int c = 0; c < `MVM_DIM; c++) begin
            operand_vector[c] = (mixed && (c % 3 == 0)) ? ELEM_MAX : ELEM_MIN;
        end
    endtask

    // Streams one job in and waits until all its results were taken
    task automatic run_job(input string name, input bit load_matrix, input bit gaps,
                           input bit stalls);
        mvm_pkg::elem_t stream [$];
        int             sent;
        current_test = name;
        stall_output = stalls;
        if (load_matrix) begin
            for (int r = 0; r < `MVM_DIM; r++) begin
                for (int c = 0; c < `MVM_DIM; c++) begin
                    stream.push_back(matrix[r][c]);   // Row-major
                end
            end
        end
        for (int c = 0; c < `MVM_DIM; c++) begin
            stream.push_back(operand_vector[c]);
        end
        for (int r = 0; r < `MVM_DIM; r++) begin
            expected_q.push_back(dot_product(r));
        end
        results_target = results_seen + `MVM_DIM;
        new_matrix = load_matrix;
        sent = 0;
        while (sent < stream.size()) begin
            @(negedge clk);
            if (gaps && (($random(seed) & 3) == 0)) begin
                input_valid = 1'b0;
            end else begin
                input_valid = 1'b1;
                input_data = stream[sent];
                if (input_ready) sent++;      // Taken on the next rising edge
            end
        end
        @(negedge clk);
        input_valid = 1'b0;
        wait (results_seen == results_target);
    endtask

    initial begin : stimulus
        clk = 1'b0;
        reset = 1'b1;
        input_valid = 1'b0;
        input_data = '0;
        new_matrix = 1'b0;
        output_ready = 1'b0;
        stall_output = 1'b0;
        results_seen = 0;
        results_target = 0;
        current_test = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Nothing may start while input_valid stays low
        repeat (4) begin
            @(negedge clk);
            check_flag("idle input_ready", 1'b0, input_ready);
            check_flag("idle output_valid", 1'b0, output_valid);
        end

        random_matrix();
        random_vector();
        run_job("random_full", 1'b1, 1'b0, 1'b0);
        random_vector();
        run_job("reuse_matrix", 1'b0, 1'b0, 1'b0);   // Old matrix stays stored
        random_matrix();
        random_vector();
        run_job("gaps_full", 1'b1, 1'b1, 1'b1);
        random_vector();
        run_job("gaps_reuse", 1'b0, 1'b1, 1'b1);
        extreme_operands(1'b0);
        run_job("all_min", 1'b1, 1'b0, 1'b0);         // 2^25 per row wraps to zero
        extreme_operands(1'b1);
        run_job("mixed_extreme", 1'b1, 1'b1, 1'b1);

        @(negedge clk);
        check_flag("final input_ready", 1'b0, input_ready);
        check_flag("final output_valid", 1'b0, output_valid);
        $display("RESULT: PASS");
        $finish;
    end

    // Drives output back-pressure and compares every transfer
    initial begin : compare_outputs
        mvm_pkg::acc_t expected;
        mvm_pkg::acc_t held_data;
        logic          held;
        held = 1'b0;
        held_data = '0;
        forever begin
            @(negedge clk);
            if (held) begin
                check_flag({current_test, " held output_valid"}, 1'b1, output_valid);
                check_result({current_test, " held output_data"}, held_data, output_data);
            end
            if (output_valid && stall_output) output_ready = ($random(seed) & 3) != 0;
            else output_ready = 1'b1;
            held = output_valid && !output_ready;
            held_data = output_data;
            if (output_valid && output_ready) begin
                if (expected_q.size() == 0) begin
                    $display("An output transfer happened with no result pending");
                    $display("RESULT: FAIL");
                    $fatal(1, "Unexpected output");
                end else begin
                    expected = expected_q.pop_front();
                    check_result(current_test, expected, output_data);
                    results_seen++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the jobs did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- mvm8.f
+incdir+logic
logic/mvm_pkg.sv
logic/mvm_control.sv
logic/element_counter.sv
logic/operand_memory.sv
logic/mac_lane.sv
logic/result_buffer.sv
logic/mvm8.sv
testbench/mvm8_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the matrix-vector multiplier testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
SIM_BIN=mvm8_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module mvm8_tb \
    -f mvm8.f \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass line not found in $LOG_FILE"
exit 1
